//--- logic/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    // Primary opcode field
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        ADDIU   = 6'h09,
        LUI     = 6'h0f,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } r_format_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [15:0] imm;
    } i_format_t;

    // One fetched word, seen as either layout
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_u;

endpackage

//--- logic/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, SLT, SLL, SRL, LUI
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::reg_addr_t dest;
        logic [4:0]         shamt;
        isa_pkg::word_t     rs_data;
        isa_pkg::word_t     rt_data;
        isa_pkg::word_t     imm_ext;
    } idex_t;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic               mem_read;
        logic               mem_write;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     result;
        isa_pkg::word_t     store_data;
    } exmem_t;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     data;
    } memwb_t;

    // Data port request, word wide
    typedef struct packed {
        logic           read;
        logic           write;
        isa_pkg::word_t addr;
        isa_pkg::word_t wdata;
    } dmem_req_t;

    typedef enum logic [1:0] {
        FROM_REG = 2'd0,
        FROM_MEM = 2'd1,
        FROM_WB  = 2'd2
    } fwd_sel_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import isa_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   pc_en,
    input  logic   ifid_en,
    input  word_t  imem_data,
    output word_t  imem_addr,
    output instr_u ifid_instr,
    output logic   ifid_valid
);

    word_t pc;

    // Sequential fetch only, no redirects
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset) begin
            ifid_valid <= 1'b0;
        end else if (ifid_en) begin
            ifid_valid <= 1'b1;
            ifid_instr <= imem_data;
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  instr_u    ifid_instr,
    input  logic      ifid_valid,
    input  logic      idex_bubble,
    input  logic      pipe_en,
    input  memwb_t    wb,
    input  reg_addr_t dbg_addr,
    output word_t     dbg_data,
    output idex_t     idex
);

    //////////////////////////////////////////////////////////////////////
    // Decoder
    //////////////////////////////////////////////////////////////////////

    ctrl_t     id_ctrl;
    reg_addr_t id_dest;
    word_t     id_imm;

    always_comb begin
        id_ctrl        = '0;
        id_ctrl.alu_op = pipe_pkg::ADD;
        id_dest        = ifid_instr.i.rt;
        id_imm         = {{16{ifid_instr.i.imm[15]}}, ifid_instr.i.imm};
        case (ifid_instr.r.opcode)
            SPECIAL: begin
                id_dest           = ifid_instr.r.rd;
                id_ctrl.reg_write = 1'b1;
                case (ifid_instr.r.funct)
                    ADDU:         id_ctrl.alu_op = pipe_pkg::ADD;
                    SUBU:         id_ctrl.alu_op = pipe_pkg::SUB;
                    isa_pkg::AND: id_ctrl.alu_op = pipe_pkg::AND;
                    isa_pkg::OR:  id_ctrl.alu_op = pipe_pkg::OR;
                    isa_pkg::SLT: id_ctrl.alu_op = pipe_pkg::SLT;
                    isa_pkg::SLL: id_ctrl.alu_op = pipe_pkg::SLL;
                    isa_pkg::SRL: id_ctrl.alu_op = pipe_pkg::SRL;
                    default:      id_ctrl.reg_write = 1'b0;
                endcase
            end
            ADDIU: begin
                id_ctrl.use_imm   = 1'b1;
                id_ctrl.reg_write = 1'b1;
            end
            isa_pkg::LUI: begin
                id_ctrl.use_imm   = 1'b1;
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_op    = pipe_pkg::LUI;
                id_imm            = {16'b0, ifid_instr.i.imm};
            end
            LW: begin
                id_ctrl.use_imm   = 1'b1;
                id_ctrl.reg_write = 1'b1;
                id_ctrl.mem_read  = 1'b1;
            end
            SW: begin
                id_ctrl.use_imm   = 1'b1;
                id_ctrl.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    word_t regs [32];
    logic  wb_we;
    word_t rs_data;
    word_t rt_data;

    assign wb_we = wb.valid & wb.reg_write & (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Write-through so a result in WB is seen in the same cycle
    function automatic word_t read_reg(input reg_addr_t addr);
        word_t value;
        value = regs[addr];
        if (wb_we && wb.dest == addr) value = wb.data;
        if (addr == '0) value = '0;
        return value;
    endfunction

    always_comb begin
        rs_data  = read_reg(ifid_instr.r.rs);
        rt_data  = read_reg(ifid_instr.r.rt);
        dbg_data = read_reg(dbg_addr);
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            idex.valid <= 1'b0;
        end else if (pipe_en) begin
            idex.valid   <= ifid_valid & ~idex_bubble;
            idex.ctrl    <= id_ctrl;
            idex.rs      <= ifid_instr.r.rs;
            idex.rt      <= ifid_instr.r.rt;
            idex.dest    <= id_dest;
            idex.shamt   <= ifid_instr.r.shamt;
            idex.rs_data <= rs_data;
            idex.rt_data <= rt_data;
            idex.imm_ext <= id_imm;
        end
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     pipe_en,
    input  idex_t    idex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  memwb_t   wb,
    output exmem_t   exmem
);

    //////////////////////////////////////////////////////////////////////
    // Operand forwarding
    //////////////////////////////////////////////////////////////////////

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t alu_out;

    always_comb begin
        case (fwd_a)
            FROM_MEM: op_a = exmem.result;
            FROM_WB:  op_a = wb.data;
            default:  op_a = idex.rs_data;
        endcase
        case (fwd_b)
            FROM_MEM: op_b_reg = exmem.result;
            FROM_WB:  op_b_reg = wb.data;
            default:  op_b_reg = idex.rt_data;
        endcase
    end

    assign op_b = idex.ctrl.use_imm ? idex.imm_ext : op_b_reg;

    //////////////////////////////////////////////////////////////////////
    // ALU and shifter
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (idex.ctrl.alu_op)
            pipe_pkg::ADD: alu_out = op_a + op_b;
            pipe_pkg::SUB: alu_out = op_a - op_b;
            pipe_pkg::AND: alu_out = op_a & op_b;
            pipe_pkg::OR:  alu_out = op_a | op_b;
            pipe_pkg::SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            // Shifts act on rt by the instruction's shamt
            pipe_pkg::SLL: alu_out = op_b_reg << idex.shamt;
            pipe_pkg::SRL: alu_out = op_b_reg >> idex.shamt;
            pipe_pkg::LUI: alu_out = {idex.imm_ext[15:0], 16'b0};
            default:       alu_out = op_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (reset) begin
            exmem.valid     <= 1'b0;
            exmem.reg_write <= 1'b0;
            exmem.mem_read  <= 1'b0;
            exmem.mem_write <= 1'b0;
        end else if (pipe_en) begin
            exmem.valid      <= idex.valid;
            exmem.reg_write  <= idex.valid & idex.ctrl.reg_write;
            exmem.mem_read   <= idex.valid & idex.ctrl.mem_read;
            exmem.mem_write  <= idex.valid & idex.ctrl.mem_write;
            exmem.dest       <= idex.dest;
            exmem.result     <= alu_out;
            exmem.store_data <= op_b_reg;
        end
    end

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pipe_en,
    input  exmem_t    exmem,
    input  word_t     dmem_rdata,
    output dmem_req_t dmem_req,
    output memwb_t    wb
);

    // Request comes straight from EX/MEM, so it holds while frozen
    assign dmem_req.read  = exmem.valid & exmem.mem_read;
    assign dmem_req.write = exmem.valid & exmem.mem_write;
    assign dmem_req.addr  = exmem.result;
    assign dmem_req.wdata = exmem.store_data;

    // MEM/WB register with load or ALU result
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid     <= 1'b0;
            wb.reg_write <= 1'b0;
        end else if (pipe_en) begin
            wb.valid     <= exmem.valid;
            wb.reg_write <= exmem.valid & exmem.reg_write;
            wb.dest      <= exmem.dest;
            wb.data      <= exmem.mem_read ? dmem_rdata : exmem.result;
        end
    end

endmodule

//--- logic/hazard_control.sv
`timescale 1ns/1ps

module hazard_control
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     mem_stall,
    input  instr_u   ifid_instr,
    input  logic     ifid_valid,
    input  idex_t    idex,
    input  exmem_t   exmem,
    input  memwb_t   wb,
    output logic     pc_en,
    output logic     ifid_en,
    output logic     idex_bubble,
    output logic     pipe_en,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    logic uses_rt;
    logic load_use;

    // Only R-type and stores read rt as a source
    assign uses_rt = (ifid_instr.r.opcode == SPECIAL) || (ifid_instr.r.opcode == SW);

    assign load_use = ifid_valid && idex.valid && idex.ctrl.mem_read && (idex.dest != '0) &&
                      ((idex.dest == ifid_instr.r.rs) ||
                       (uses_rt && idex.dest == ifid_instr.r.rt));

    assign pipe_en     = ~mem_stall;
    assign pc_en       = ~mem_stall & ~load_use;
    assign ifid_en     = ~mem_stall & ~load_use;
    assign idex_bubble = ~mem_stall & load_use;

    // Nearest producer wins, register 0 stays on the file path
    function automatic fwd_sel_t pick_source(input reg_addr_t src);
        if (src == '0) return FROM_REG;
        if (exmem.valid && exmem.reg_write && exmem.dest == src) return FROM_MEM;
        if (wb.valid && wb.reg_write && wb.dest == src) return FROM_WB;
        return FROM_REG;
    endfunction

    always_comb begin
        fwd_a = pick_source(idex.rs);
        fwd_b = pick_source(idex.rt);
    end

endmodule

//--- logic/mips_core.sv
`timescale 1ns/1ps

module mips_core
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata,
    input  logic      mem_stall,
    input  reg_addr_t dbg_addr,
    output word_t     dbg_data
);

    //////////////////////////////////////////////////////////////////////
    // Stage registers and control
    //////////////////////////////////////////////////////////////////////

    instr_u   ifid_instr;
    logic     ifid_valid;
    idex_t    idex;
    exmem_t   exmem;
    memwb_t   wb;
    logic     pc_en;
    logic     ifid_en;
    logic     idex_bubble;
    logic     pipe_en;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset), .pc_en(pc_en), .ifid_en(ifid_en),
        .imem_data(imem_data), .imem_addr(imem_addr),
        .ifid_instr(ifid_instr), .ifid_valid(ifid_valid)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .ifid_instr(ifid_instr), .ifid_valid(ifid_valid),
        .idex_bubble(idex_bubble), .pipe_en(pipe_en), .wb(wb),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data), .idex(idex)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .pipe_en(pipe_en), .idex(idex),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .wb(wb), .exmem(exmem)
    );

    memory_stage u_memory (
        .clk(clk), .reset(reset), .pipe_en(pipe_en), .exmem(exmem),
        .dmem_rdata(dmem_rdata), .dmem_req(dmem_req), .wb(wb)
    );

    // Stall and forwarding decisions
    hazard_control u_hazard (
        .mem_stall(mem_stall), .ifid_instr(ifid_instr), .ifid_valid(ifid_valid),
        .idex(idex), .exmem(exmem), .wb(wb), .pc_en(pc_en), .ifid_en(ifid_en),
        .idex_bubble(idex_bubble), .pipe_en(pipe_en), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

endmodule

//--- verif/core_props.sv
`timescale 1ns/1ps

module core_props
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input logic      clk,
    input logic      reset,
    input logic      mem_stall,
    input logic      idex_bubble,
    input word_t     imem_addr,
    input dmem_req_t dmem_req,
    input reg_addr_t dbg_addr,
    input word_t     dbg_data
);

    //////////////////////////////////////////////////////////////////////
    // Expected results of the test program
    //////////////////////////////////////////////////////////////////////

    localparam int N_STORES  = 7;
    localparam int N_CHECKED = 19;

    localparam word_t STORE_ADDR [N_STORES] = '{
        32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18
    };
    localparam word_t STORE_DATA [N_STORES] = '{
        32'd17, 32'd12, 32'h0080_0110, 32'd34, 32'h5a5a_0034, 32'd12, 32'd16
    };

    // r0 through r18 once the last store is out
    localparam word_t FINAL_REG [N_CHECKED] = '{
        32'd0,         32'd5,         32'd12,        32'd17,
        32'd12,        32'h8000_0000, 32'h8000_0011, 32'd1,
        32'd0,         32'h0000_0110, 32'h0080_0000, 32'h0080_0110,
        32'd17,        32'd34,        32'h5a5a_0040, 32'h5a5a_0034,
        32'd4,         32'd12,        32'd16
    };

    int   store_idx;
    logic done;
    int   fail_count = 0;

    // Stores accepted by the data port so far
    always_ff @(posedge clk) begin
        if (reset) begin
            store_idx <= 0;
        end else if (dmem_req.write && !mem_stall) begin
            store_idx <= store_idx + 1;
        end
    end

    assign done = (store_idx >= N_STORES);

    //////////////////////////////////////////////////////////////////////
    // Pipeline properties
    //////////////////////////////////////////////////////////////////////

    reset_state: assert property (@(posedge clk)
        reset |=> (imem_addr == RESET_PC) && !dmem_req.read && !dmem_req.write)
    else begin
        fail_count++;
        $error("mismatch at %0t: imem_addr or dmem_req wrong after reset", $time);
    end

    pc_advance: assert property (@(posedge clk) disable iff (reset)
        !mem_stall && !idex_bubble |=> imem_addr == $past(imem_addr) + 32'd4)
    else begin
        fail_count++;
        $error("mismatch at %0t: imem_addr did not advance by 4", $time);
    end

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        mem_stall |=> $stable(imem_addr) && $stable(dmem_req))
    else begin
        fail_count++;
        $error("mismatch at %0t: imem_addr or dmem_req moved under mem_stall", $time);
    end

    // One held cycle, then fetch moves on
    load_use_hold: assert property (@(posedge clk) disable iff (reset)
        idex_bubble |=> $stable(imem_addr) && !idex_bubble)
    else begin
        fail_count++;
        $error("mismatch at %0t: load-use stall was not exactly one cycle", $time);
    end

    store_match: assert property (@(posedge clk) disable iff (reset)
        dmem_req.write && !mem_stall |->
            (store_idx < N_STORES) && (dmem_req.addr == STORE_ADDR[store_idx]) &&
            (dmem_req.wdata == STORE_DATA[store_idx]))
    else begin
        fail_count++;
        $error("mismatch at %0t: store address or data differs from the next expected", $time);
    end

    final_regs: assert property (@(posedge clk) disable iff (reset)
        done && (dbg_addr < N_CHECKED) |-> dbg_data == FINAL_REG[dbg_addr])
    else begin
        fail_count++;
        $error("mismatch at %0t: register %0d reads %h", $time, dbg_addr, dbg_data);
    end

endmodule

bind mips_core core_props #(.RESET_PC(RESET_PC)) u_props (
    .clk(clk), .reset(reset), .mem_stall(mem_stall), .idex_bubble(idex_bubble),
    .imem_addr(imem_addr), .dmem_req(dmem_req), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
);

//--- verif/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam word_t RESET_PC   = 32'h0000_0000;
    localparam int    IMEM_WORDS = 64;
    localparam int    DMEM_WORDS = 64;
    localparam int    PROG_LEN   = 25;
    // Four cycles per instruction plus margin for reset, stalls and the sweep
    localparam int    TIMEOUT_CYCLES = PROG_LEN * 4 + 300;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      mem_stall;
    reg_addr_t dbg_addr;
    word_t     dbg_data;

    word_t  imem [IMEM_WORDS];
    word_t  dmem [DMEM_WORDS];
    integer seed;
    int     cycle_count;
    int     timeout_count;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    mips_core #(.RESET_PC(RESET_PC)) uut (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .mem_stall(mem_stall),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Past the program the fetch sees zero words, which decode as nops
    assign imem_data  = (imem_addr[31:2] < IMEM_WORDS) ? imem[imem_addr[7:2]] : '0;

    // Read data only answers a read request
    assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[7:2]] : '0;

    always @(posedge clk) begin
        if (dmem_req.write && !mem_stall) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    function automatic word_t r_type_word(input funct_t fn, input reg_addr_t rs,
                                          input reg_addr_t rt, input reg_addr_t rd,
                                          input logic [4:0] shamt);
        return {SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t i_type_word(input opcode_t op, input reg_addr_t rs,
                                          input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic load_program();
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem[a] = '0;
        end
        imem[0]  = i_type_word(ADDIU, 5'd0, 5'd1, 16'd5);
        imem[1]  = i_type_word(ADDIU, 5'd1, 5'd2, 16'd7);
        imem[2]  = r_type_word(ADDU, 5'd1, 5'd2, 5'd3, 5'd0);
        imem[3]  = r_type_word(SUBU, 5'd3, 5'd1, 5'd4, 5'd0);
        imem[4]  = i_type_word(SW, 5'd0, 5'd3, 16'd0);
        imem[5]  = i_type_word(SW, 5'd0, 5'd4, 16'd4);
        imem[6]  = i_type_word(isa_pkg::LUI, 5'd0, 5'd5, 16'h8000);
        imem[7]  = r_type_word(isa_pkg::OR, 5'd5, 5'd3, 5'd6, 5'd0);
        imem[8]  = r_type_word(isa_pkg::SLT, 5'd6, 5'd1, 5'd7, 5'd0);
        imem[9]  = r_type_word(isa_pkg::SLT, 5'd1, 5'd6, 5'd8, 5'd0);
        imem[10] = r_type_word(isa_pkg::SLL, 5'd0, 5'd6, 5'd9, 5'd4);
        imem[11] = r_type_word(isa_pkg::SRL, 5'd0, 5'd6, 5'd10, 5'd8);
        imem[12] = r_type_word(isa_pkg::OR, 5'd9, 5'd10, 5'd11, 5'd0);
        imem[13] = i_type_word(SW, 5'd0, 5'd11, 16'd8);
        // Load-use on rs with the result stored afterwards
        imem[14] = i_type_word(LW, 5'd0, 5'd12, 16'd0);
        imem[15] = r_type_word(ADDU, 5'd12, 5'd12, 5'd13, 5'd0);
        imem[16] = i_type_word(SW, 5'd0, 5'd13, 16'd12);
        imem[17] = i_type_word(LW, 5'd0, 5'd14, 16'd64);
        imem[18] = r_type_word(SUBU, 5'd14, 5'd2, 5'd15, 5'd0);
        imem[19] = r_type_word(isa_pkg::AND, 5'd15, 5'd4, 5'd16, 5'd0);
        imem[20] = i_type_word(SW, 5'd0, 5'd15, 16'd16);
        // Load-use on the store data
        imem[21] = i_type_word(LW, 5'd0, 5'd17, 16'd4);
        imem[22] = i_type_word(SW, 5'd0, 5'd17, 16'd20);
        imem[23] = r_type_word(ADDU, 5'd16, 5'd17, 5'd18, 5'd0);
        imem[24] = i_type_word(SW, 5'd0, 5'd18, 16'd24);
    endtask

    task automatic fill_data_memory();
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a] = {16'h5a5a, 16'(a * 4)};
        end
    endtask

    task automatic sweep_registers();
        for (int r = 0; r < 32; r++) begin
            dbg_addr = r[4:0];
            @(negedge clk);
        end
    endtask

    task automatic finish_run();
        int total;
        total = uut.u_props.fail_count + timeout_count;
        $display("assertion failures: %0d, timeouts: %0d", uut.u_props.fail_count,
                 timeout_count);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed      = 61895;
        reset     = 1'b1;
        mem_stall = 1'b0;
        dbg_addr  = '0;
        load_program();
        fill_data_memory();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Random stalls, about one cycle in four, until the last store
        while (!uut.u_props.done) begin
            @(negedge clk);
            mem_stall = (($random(seed) & 3) == 0) && !uut.u_props.done;
        end
        @(negedge clk);
        mem_stall = 1'b0;
        sweep_registers();
        @(negedge clk);
        finish_run();
    end

    initial begin
        cycle_count   = 0;
        timeout_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timeout_count++;
        $display("Timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run();
    end

endmodule

//--- src.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_control.sv
logic/mips_core.sv
verif/core_props.sv
verif/core_tb.sv
